// ==== verilog/cop_cfg.svh ====
/*
 * Coprocessor build constants
 *  - custom-0 major opcode
 *  - XCR count
 *  - largest legal pack-width code
 */
`ifndef COP_CFG_SVH
`define COP_CFG_SVH

// Major opcode shared by every coprocessor instruction
`define COP_OPCODE  7'b0001011

`define COP_NUM_XCR 16          // Coprocessor registers

// Codes above this are illegal for packed arithmetic
`define COP_PW_MAX  3'd4

`endif

// ==== verilog/cop_pkg.sv ====
/*
 * Shared coprocessor types
 *  - instruction class, subclass and pack width codes
 *  - instruction word union, register and immediate layouts
 *  - decode and response bundles
 */
`default_nettype none

package cop_pkg;

    typedef enum logic [2:0] {
        CLASS_PACKED_ARITH = 3'd0,
        CLASS_BITWISE      = 3'd1,
        CLASS_MOVE         = 3'd2   // 3 to 7 reserved
    } cop_class_e;

    // Subclass codes restart at zero in every class
    typedef logic [2:0] cop_sclass_e;

    localparam cop_sclass_e SC_PADD    = 3'd0;
    localparam cop_sclass_e SC_PSUB    = 3'd1;
    localparam cop_sclass_e SC_PSLL_I  = 3'd2;
    localparam cop_sclass_e SC_PSRL_I  = 3'd3;
    localparam cop_sclass_e SC_PROT_I  = 3'd4;

    localparam cop_sclass_e SC_LD_LI   = 3'd0;
    localparam cop_sclass_e SC_LD_HI   = 3'd1;

    localparam cop_sclass_e SC_GPR2XCR = 3'd0;
    localparam cop_sclass_e SC_XCR2GPR = 3'd1;
    localparam cop_sclass_e SC_CMOV    = 3'd2;

    typedef enum logic [2:0] {
        PW_32 = 3'd0,
        PW_16 = 3'd1,
        PW_8  = 3'd2,
        PW_4  = 3'd3,
        PW_2  = 3'd4
    } cop_pw_e;

    // Register format, GPR index of a move is {rd_hi, pw[2:1]}
    typedef struct packed {
        logic [2:0]  rd_hi;
        logic [2:0]  pw;
        logic        shamt_hi;      // Shift amount is {shamt_hi, crs2}
        logic [3:0]  crs2;
        logic [3:0]  crs1;
        cop_sclass_e sclass;
        logic [3:0]  crd;
        logic [2:0]  cls;
        logic [6:0]  opcode;
    } cop_insn_r_t;

    // Immediate format for the half-register loads
    typedef struct packed {
        logic [14:0] imm;           // Bits 15:1 of the 16-bit immediate
        cop_sclass_e sclass;
        logic [3:0]  crd;
        logic [2:0]  cls;
        logic [6:0]  opcode;
    } cop_insn_i_t;

    typedef union packed {
        cop_insn_r_t r;
        cop_insn_i_t i;
    } cop_insn_u;

    typedef struct packed {
        logic        exception;
        cop_class_e  cls;
        cop_sclass_e sclass;
        cop_pw_e     pw;
        logic [3:0]  crs1;
        logic [3:0]  crs2;
        logic [3:0]  crs3;
        logic [3:0]  crd;
        logic [4:0]  rd;
        logic [31:0] imm;
        logic        xcr_we;
        logic        gpr_we;
    } cop_dec_t;

    typedef struct packed {
        logic        exception;
        logic        gpr_we;
        logic [4:0]  rd;
        logic [31:0] gpr_wdata;
    } cop_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/cop_idecode.sv ====
/*
 * Combinational instruction decoder
 *  - legality checks on opcode, class, subclass and pack width
 *  - operand selection and immediate build
 *  - register write controls
 */
`timescale 1ns/1ps
`default_nettype none

`include "cop_cfg.svh"

module cop_idecode
    import cop_pkg::*;
(
    input  cop_insn_u insn_i,   // Instruction word from the host
    output cop_dec_t  dec_o     // Decoded fields and controls
);

    cop_sclass_e sc;
    logic        opcode_ok;
    logic        is_arith;
    logic        is_bitwise;
    logic        is_move;
    logic        class_ok;
    logic        sclass_ok;
    logic        bad_pw;
    logic        legal;

    logic        dec_padd;
    logic        dec_psub;
    logic        dec_psll_i;
    logic        dec_psrl_i;
    logic        dec_prot_i;
    logic        dec_ld_li;
    logic        dec_ld_hi;
    logic        dec_gpr2xcr;
    logic        dec_xcr2gpr;
    logic        dec_cmov;

    logic        imm_sh;
    logic        imm_li;
    logic        crd_in_crs3;
    logic [4:0]  shamt;

    assign sc         = insn_i.r.sclass;
    assign opcode_ok  = insn_i.r.opcode == `COP_OPCODE;

    assign is_arith   = insn_i.r.cls == CLASS_PACKED_ARITH;
    assign is_bitwise = insn_i.r.cls == CLASS_BITWISE;
    assign is_move    = insn_i.r.cls == CLASS_MOVE;
    assign class_ok   = is_arith || is_bitwise || is_move;

    // Individual instructions
    assign dec_padd    = is_arith   && sc == SC_PADD;
    assign dec_psub    = is_arith   && sc == SC_PSUB;
    assign dec_psll_i  = is_arith   && sc == SC_PSLL_I;
    assign dec_psrl_i  = is_arith   && sc == SC_PSRL_I;
    assign dec_prot_i  = is_arith   && sc == SC_PROT_I;
    assign dec_ld_li   = is_bitwise && sc == SC_LD_LI;
    assign dec_ld_hi   = is_bitwise && sc == SC_LD_HI;
    assign dec_gpr2xcr = is_move    && sc == SC_GPR2XCR;
    assign dec_xcr2gpr = is_move    && sc == SC_XCR2GPR;
    assign dec_cmov    = is_move    && sc == SC_CMOV;

    assign sclass_ok =
        dec_padd    || dec_psub    || dec_psll_i || dec_psrl_i || dec_prot_i ||
        dec_ld_li   || dec_ld_hi   ||
        dec_gpr2xcr || dec_xcr2gpr || dec_cmov;

    // Pack width only matters for packed arithmetic
    assign bad_pw = is_arith && (insn_i.r.pw > `COP_PW_MAX);

    assign legal  = opcode_ok && class_ok && sclass_ok && !bad_pw;

    // Immediate sources
    assign imm_sh = dec_psll_i || dec_psrl_i || dec_prot_i;
    assign imm_li = dec_ld_li  || dec_ld_hi;
    assign shamt  = {insn_i.r.shamt_hi, insn_i.r.crs2};

    // Old crd value is needed as a third operand
    assign crd_in_crs3 = dec_ld_li || dec_ld_hi || dec_cmov;

    assign dec_o.exception = !legal;
    assign dec_o.cls       = cop_class_e'(insn_i.r.cls);
    assign dec_o.sclass    = sc;
    assign dec_o.pw        = cop_pw_e'(insn_i.r.pw);
    assign dec_o.crs1      = insn_i.r.crs1;
    assign dec_o.crs2      = insn_i.r.crs2;
    assign dec_o.crs3      = crd_in_crs3 ? insn_i.r.crd : 4'd0;
    assign dec_o.crd       = insn_i.r.crd;
    assign dec_o.rd        = {insn_i.r.rd_hi, insn_i.r.pw[2:1]};

    assign dec_o.imm =
        {32{imm_sh}} & {27'b0, shamt}                  |
        {32{imm_li}} & {16'b0, insn_i.i.imm, 1'b0}     ;

    // Nothing is written for an illegal encoding
    assign dec_o.xcr_we = legal && (is_arith || imm_li || dec_gpr2xcr || dec_cmov);
    assign dec_o.gpr_we = legal && dec_xcr2gpr;

    always_comb begin
        assert (!(dec_o.xcr_we && dec_o.gpr_we))
            else $error("decoder requested both XCR and GPR write");
    end

endmodule

`default_nettype wire

// ==== verilog/cop_regfile.sv ====
/*
 * XCR register file
 *  - three asynchronous read ports
 *  - one synchronous write port, cleared by reset
 */
`timescale 1ns/1ps
`default_nettype none

`include "cop_cfg.svh"

module cop_regfile (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic [3:0]  rd1_addr_i,
    input  logic [3:0]  rd2_addr_i,
    input  logic [3:0]  rd3_addr_i,
    output logic [31:0] rd1_data_o,
    output logic [31:0] rd2_data_o,
    output logic [31:0] rd3_data_o,
    input  logic        wr_en_i,
    input  logic [3:0]  wr_addr_i,
    input  logic [31:0] wr_data_i
);

    logic [31:0] xcr_q [`COP_NUM_XCR];

    assign rd1_data_o = xcr_q[rd1_addr_i];
    assign rd2_data_o = xcr_q[rd2_addr_i];
    assign rd3_data_o = xcr_q[rd3_addr_i];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `COP_NUM_XCR; i++) begin
                xcr_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            xcr_q[wr_addr_i] <= wr_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cop_palu.sv ====
/*
 * Stage two result unit
 *  - lane-wise add, subtract, shift and rotate at all pack widths
 *  - half-register loads, GPR moves and conditional move
 */
`timescale 1ns/1ps
`default_nettype none

`include "cop_cfg.svh"

module cop_palu
    import cop_pkg::*;
(
    input  cop_dec_t    dec_i,
    input  logic [31:0] rs1_i,
    input  logic [31:0] rs2_i,
    input  logic [31:0] rs3_i,          // Old crd value
    input  logic [31:0] gpr_i,
    output logic [31:0] xcr_wdata_o,
    output logic [31:0] gpr_wdata_o
);

    // One result word per pack width, index is the pw code
    logic [4:0][31:0] add_r;
    logic [4:0][31:0] sub_r;
    logic [4:0][31:0] sll_r;
    logic [4:0][31:0] srl_r;
    logic [4:0][31:0] rot_r;

    logic [2:0]       pw_idx;
    logic             pw_ok;
    logic [31:0]      arith_res;

    for (genvar w = 0; w < 5; w++) begin : g_pw
        localparam int LW = 32 >> w;        // Lane width
        localparam int SW = $clog2(LW);

        logic [SW-1:0] sh;                  // Shamt modulo lane width
        assign sh = dec_i.imm[SW-1:0];

        for (genvar l = 0; l < 32 / LW; l++) begin : g_lane
            logic [LW-1:0]   a;
            logic [LW-1:0]   b;
            logic [2*LW-1:0] rot;

            assign a   = rs1_i[l*LW +: LW];
            assign b   = rs2_i[l*LW +: LW];
            assign rot = {a, a} >> sh;

            // Carries stop at the lane edge
            assign add_r[w][l*LW +: LW] = a + b;
            assign sub_r[w][l*LW +: LW] = a - b;
            assign sll_r[w][l*LW +: LW] = a << sh;
            assign srl_r[w][l*LW +: LW] = a >> sh;
            assign rot_r[w][l*LW +: LW] = rot[LW-1:0];
        end
    end

    assign pw_idx = dec_i.pw;
    assign pw_ok  = pw_idx <= `COP_PW_MAX;

    always_comb begin
        arith_res = '0;
        if (pw_ok) begin
            case (dec_i.sclass)
                SC_PADD:   arith_res = add_r[pw_idx];
                SC_PSUB:   arith_res = sub_r[pw_idx];
                SC_PSLL_I: arith_res = sll_r[pw_idx];
                SC_PSRL_I: arith_res = srl_r[pw_idx];
                SC_PROT_I: arith_res = rot_r[pw_idx];
                default:   arith_res = '0;
            endcase
        end
    end

    always_comb begin
        case (dec_i.cls)
            CLASS_PACKED_ARITH: xcr_wdata_o = arith_res;
            CLASS_BITWISE: begin
                case (dec_i.sclass)
                    SC_LD_LI: xcr_wdata_o = {rs3_i[31:16], dec_i.imm[15:0]};
                    SC_LD_HI: xcr_wdata_o = {dec_i.imm[15:0], rs3_i[15:0]};
                    default:  xcr_wdata_o = '0;
                endcase
            end
            CLASS_MOVE: begin
                case (dec_i.sclass)
                    SC_GPR2XCR: xcr_wdata_o = gpr_i;
                    SC_CMOV:    xcr_wdata_o = (|rs1_i) ? rs2_i : rs3_i;
                    default:    xcr_wdata_o = '0;   // xcr2gpr writes no XCR
                endcase
            end
            default: xcr_wdata_o = '0;
        endcase
    end

    assign gpr_wdata_o = dec_i.gpr_we ? rs1_i : '0;    // Only xcr2gpr

    // Decoder screens out wide pack codes before they get here
    always_comb begin
        if (dec_i.cls == CLASS_PACKED_ARITH && !dec_i.exception) begin
            assert (dec_i.pw <= `COP_PW_MAX)
                else $error("packed op reached ALU with pw %0d", dec_i.pw);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cop_top.sv ====
/*
 * Coprocessor top level
 *  - stage one decode, XCR read and result bypass
 *  - stage two execute, XCR write-back and registered response
 */
`timescale 1ns/1ps
`default_nettype none

module cop_top
    import cop_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        insn_valid_i,   // One cycle per instruction
    input  cop_insn_u   insn_i,
    input  logic [31:0] gpr_rs1_i,      // GPR value read by the host
    output logic        rsp_valid_o,
    output cop_rsp_t    rsp_o
);

    cop_dec_t    dec_s1;
    logic [31:0] rf_rd1;
    logic [31:0] rf_rd2;
    logic [31:0] rf_rd3;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] op3;

    logic        s2_valid_q;
    cop_dec_t    s2_dec_q;
    logic [31:0] s2_rs1_q;
    logic [31:0] s2_rs2_q;
    logic [31:0] s2_rs3_q;
    logic [31:0] s2_gpr_q;

    logic [31:0] xcr_wdata;
    logic [31:0] gpr_wdata;
    logic        xcr_wr;

    cop_idecode u_idecode (
        .insn_i (insn_i),
        .dec_o  (dec_s1)
    );

    cop_regfile u_regfile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rd1_addr_i (dec_s1.crs1),
        .rd2_addr_i (dec_s1.crs2),
        .rd3_addr_i (dec_s1.crs3),
        .rd1_data_o (rf_rd1),
        .rd2_data_o (rf_rd2),
        .rd3_data_o (rf_rd3),
        .wr_en_i    (xcr_wr),
        .wr_addr_i  (s2_dec_q.crd),
        .wr_data_i  (xcr_wdata)
    );

    // Stage two writes at the same edge stage one captures
    assign xcr_wr = s2_valid_q && s2_dec_q.xcr_we && !s2_dec_q.exception;

    assign op1 = (xcr_wr && s2_dec_q.crd == dec_s1.crs1) ? xcr_wdata : rf_rd1;
    assign op2 = (xcr_wr && s2_dec_q.crd == dec_s1.crs2) ? xcr_wdata : rf_rd2;
    assign op3 = (xcr_wr && s2_dec_q.crd == dec_s1.crs3) ? xcr_wdata : rf_rd3;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            s2_valid_q <= 1'b0;
        end else begin
            s2_valid_q <= insn_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (insn_valid_i) begin
            s2_dec_q <= dec_s1;
            s2_rs1_q <= op1;
            s2_rs2_q <= op2;
            s2_rs3_q <= op3;
            s2_gpr_q <= gpr_rs1_i;
        end
    end

    cop_palu u_palu (
        .dec_i       (s2_dec_q),
        .rs1_i       (s2_rs1_q),
        .rs2_i       (s2_rs2_q),
        .rs3_i       (s2_rs3_q),
        .gpr_i       (s2_gpr_q),
        .xcr_wdata_o (xcr_wdata),
        .gpr_wdata_o (gpr_wdata)
    );

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= s2_valid_q;
        end
    end

    // Illegal encodings still answer, with no GPR data
    always_ff @(posedge clk_i) begin
        if (s2_valid_q) begin
            rsp_o.exception <= s2_dec_q.exception;
            rsp_o.gpr_we    <= s2_dec_q.gpr_we && !s2_dec_q.exception;
            rsp_o.rd        <= s2_dec_q.rd;
            rsp_o.gpr_wdata <= s2_dec_q.exception ? '0 : gpr_wdata;
        end
    end

    // Fixed two-cycle latency, one response per instruction
    property p_rsp_latency;
        @(posedge clk_i) disable iff (!rst_n_i)
            $past(rst_n_i, 1) && $past(rst_n_i, 2) |->
                rsp_valid_o == $past(insn_valid_i, 2);
    endproperty

    a_rsp_latency : assert property (p_rsp_latency)
        else $error("response valid out of step with instruction strobe");

endmodule

`default_nettype wire

// ==== verification/tb_cop_model.svh ====
/*
 * Testbench reference model
 *  - Fibonacci LFSR stimulus source
 *  - instruction word builders and random instruction generator
 *  - lane-wise arithmetic and instruction effects on a model XCR file
 */
`ifndef TB_COP_MODEL_SVH
`define TB_COP_MODEL_SVH

// One LFSR step per bit taken, taps 32 22 2 1
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        v      = {v[30:0], fb};
    end
    return v;
endfunction

// Register format, f2 is crs2 or the whole shift amount
function automatic logic [31:0] enc_r(input logic [2:0] cls, input logic [2:0] sc,
                                      input logic [3:0] crd, input logic [3:0] crs1,
                                      input logic [4:0] f2, input logic [2:0] pw);
    return {3'(rand_bits(3)), pw, f2, crs1, sc, crd, cls, `COP_OPCODE};
endfunction

function automatic logic [31:0] enc_i(input logic [2:0] sc, input logic [3:0] crd,
                                      input logic [14:0] imm);
    return {imm, sc, crd, CLASS_BITWISE, `COP_OPCODE};
endfunction

function automatic logic [31:0] lane_op(input logic [2:0] sc, input int pw,
                                        input logic [31:0] a, input logic [31:0] b,
                                        input int shamt);
    int          lw;
    int          sh;
    logic [31:0] mask;
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] z;
    logic [31:0] r;
    lw   = 32 >> pw;
    sh   = shamt % lw;
    mask = (32'd1 << lw) - 32'd1;           // All ones for a full word lane
    r    = '0;
    for (int l = 0; l < 32 / lw; l++) begin
        x = (a >> (l * lw)) & mask;
        y = (b >> (l * lw)) & mask;
        case (sc)
            SC_PADD:   z = x + y;
            SC_PSUB:   z = x - y;
            SC_PSLL_I: z = x << sh;
            SC_PSRL_I: z = x >> sh;
            default:   z = (x >> sh) | (x << (lw - sh));   // Rotate right
        endcase
        r = r | ((z & mask) << (l * lw));
    end
    return r;
endfunction

// Applies one instruction to the model XCRs and gives its response
function automatic cop_rsp_t model_exec(input logic [31:0] w, input logic [31:0] gpr);
    cop_rsp_t   rsp;
    logic [2:0] cls;
    logic [2:0] sc;
    logic [2:0] pw;
    logic [3:0] crd;
    logic [3:0] crs1;
    logic       legal;
    cls  = w[9:7];
    sc   = w[16:14];
    pw   = w[28:26];
    crd  = w[13:10];
    crs1 = w[20:17];
    rsp    = '0;
    rsp.rd = w[31:27];
    case (cls)
        CLASS_PACKED_ARITH: legal = sc <= 3'd4 && pw <= 3'd4;
        CLASS_BITWISE:      legal = sc <= 3'd1;
        CLASS_MOVE:         legal = sc <= 3'd2;
        default:            legal = 1'b0;
    endcase
    legal = legal && w[6:0] == `COP_OPCODE;
    if (!legal) begin
        rsp.exception = 1'b1;
    end else if (cls == CLASS_PACKED_ARITH) begin
        xcr_m[crd] = lane_op(sc, int'(pw), xcr_m[crs1], xcr_m[w[24:21]], int'(w[25:21]));
    end else if (cls == CLASS_BITWISE) begin
        if (sc == SC_LD_LI) begin
            xcr_m[crd][15:0] = {w[31:17], 1'b0};
        end else begin
            xcr_m[crd][31:16] = {w[31:17], 1'b0};
        end
    end else if (sc == SC_GPR2XCR) begin
        xcr_m[crd] = gpr;
    end else if (sc == SC_XCR2GPR) begin
        rsp.gpr_we    = 1'b1;
        rsp.gpr_wdata = xcr_m[crs1];
    end else if (xcr_m[crs1] != 32'd0) begin
        xcr_m[crd] = xcr_m[w[24:21]];       // cmov keeps crd on a zero selector
    end
    return rsp;
endfunction

function automatic logic [31:0] rand_insn();
    logic [3:0] kind;
    logic [3:0] crd;
    logic [3:0] crs1;
    logic [4:0] f2;
    kind = 4'(rand_bits(4));
    crd  = 4'(rand_bits(4));
    crs1 = 4'(rand_bits(4));
    f2   = 5'(rand_bits(5));
    if (kind < 4'd5) begin
        return enc_r(CLASS_PACKED_ARITH, 3'(rand_bits(3) % 5), crd, crs1, f2,
                     3'(rand_bits(3) % 5));
    end else if (kind < 4'd7) begin
        return enc_i(3'(rand_bits(1)), crd, 15'(rand_bits(15)));
    end else if (kind < 4'd13) begin
        return enc_r(CLASS_MOVE, 3'(rand_bits(2) % 3), crd, crs1, f2, 3'(rand_bits(3)));
    end
    return rand_bits(32);                   // Mostly illegal words
endfunction

`endif

// ==== verification/tb_cop_top.sv ====
/*
 * Coprocessor testbench
 *  - clock, reset and instruction driver
 *  - response monitor with latency and count checks
 *  - directed and random instruction sequences
 */
`timescale 1ns/1ps
`default_nettype none

`include "cop_cfg.svh"

module tb_cop_top
    import cop_pkg::*;
();

    localparam int RSP_NEG     = 3;     // Negedges from drive to visible response
    localparam int DRAIN_LIMIT = 50;

    logic        clk;
    logic        rst_n;
    logic        insn_valid;
    cop_insn_u   insn;
    logic [31:0] gpr_rs1;
    logic        rsp_valid;
    cop_rsp_t    rsp;

    logic [31:0] lfsr_q;
    logic [31:0] xcr_m [`COP_NUM_XCR];
    cop_rsp_t    exp_q[$];
    int          due_q[$];
    int          neg_cnt;

    `include "tb_cop_model.svh"

    cop_top u_cop_top (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .insn_valid_i (insn_valid),
        .insn_i       (insn),
        .gpr_rs1_i    (gpr_rs1),
        .rsp_valid_o  (rsp_valid),
        .rsp_o        (rsp)
    );

    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_rsp(input cop_rsp_t got, input cop_rsp_t exp);
        if (got.exception !== exp.exception) begin
            abort_run($sformatf("FAILED rsp_o.exception: got %h expected %h",
                                got.exception, exp.exception));
        end else if (got.gpr_we !== exp.gpr_we) begin
            abort_run($sformatf("FAILED rsp_o.gpr_we: got %h expected %h",
                                got.gpr_we, exp.gpr_we));
        end else if (got.rd !== exp.rd) begin
            abort_run($sformatf("FAILED rsp_o.rd: got %h expected %h", got.rd, exp.rd));
        end else if (got.gpr_wdata !== exp.gpr_wdata) begin
            abort_run($sformatf("FAILED rsp_o.gpr_wdata: got %h expected %h",
                                got.gpr_wdata, exp.gpr_wdata));
        end
    endtask

    task automatic issue(input logic [31:0] w, input logic [31:0] gpr);
        @(posedge clk);
        insn_valid <= 1'b1;
        insn       <= w;
        gpr_rs1    <= gpr;
        exp_q.push_back(model_exec(w, gpr));
        due_q.push_back(neg_cnt + RSP_NEG);
    endtask

    task automatic idle(input int n);
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
            insn_valid <= 1'b0;
        end
    endtask

    task automatic write_xcr(input logic [3:0] idx, input logic [31:0] val);
        issue(enc_r(CLASS_MOVE, SC_GPR2XCR, idx, 4'd0, 5'd0, 3'(rand_bits(3))), val);
    endtask

    task automatic read_xcr(input logic [3:0] idx);
        issue(enc_r(CLASS_MOVE, SC_XCR2GPR, 4'd0, idx, 5'd0, 3'(rand_bits(3))), rand_bits(32));
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        idle(1);
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            abort_run("Timed out waiting for outstanding responses");
        end
    endtask

    // Outputs are sampled half a cycle away from the driving edge
    always @(negedge clk) begin
        neg_cnt = neg_cnt + 1;
        if (rsp_valid === 1'b1) begin
            if (due_q.size() == 0) begin
                abort_run("Response valid with no instruction outstanding");
            end else if (due_q[0] != neg_cnt) begin
                abort_run($sformatf("Response came at cycle %0d instead of cycle %0d",
                                    neg_cnt, due_q[0]));
            end else begin
                check_rsp(rsp, exp_q.pop_front());
                void'(due_q.pop_front());
            end
        end else if (due_q.size() != 0 && due_q[0] <= neg_cnt) begin
            abort_run("Expected response did not arrive");
        end
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        insn_valid = 1'b0;
        insn       = '0;
        gpr_rs1    = '0;
        lfsr_q     = 32'hbe5a4b42;
        neg_cnt    = 0;
        for (int i = 0; i < `COP_NUM_XCR; i++) begin
            xcr_m[i] = '0;
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        idle(4);                            // Monitor flags any stray response

        for (int i = 0; i < 16; i++) begin
            read_xcr(4'(i));
        end
        // Second of each pair reads through the bypass
        for (int i = 0; i < 16; i++) begin
            write_xcr(4'(i), rand_bits(32));
            read_xcr(4'(i));
        end
        drain();

        for (int pw = 0; pw < 5; pw++) begin
            for (int sc = 0; sc < 5; sc++) begin
                for (int n = 0; n < 4; n++) begin
                    write_xcr(4'd1, rand_bits(32));
                    write_xcr(4'd2, rand_bits(32));
                    issue(enc_r(CLASS_PACKED_ARITH, 3'(sc), 4'd3, 4'd1, 5'(rand_bits(5)),
                                3'(pw)), rand_bits(32));
                    read_xcr(4'd3);
                end
            end
        end
        drain();

        // Half loads, then cmov with zero and nonzero selector
        for (int n = 0; n < 16; n++) begin
            write_xcr(4'(n), rand_bits(32));
            issue(enc_i(3'(n % 2), 4'(n), 15'(rand_bits(15))), rand_bits(32));
            read_xcr(4'(n));
            write_xcr(4'd5, n[0] ? rand_bits(32) : 32'd0);
            issue(enc_r(CLASS_MOVE, SC_CMOV, 4'(15 - n), 4'd5, 5'(n), 3'd0), rand_bits(32));
            read_xcr(4'(15 - n));
        end
        drain();

        for (int n = 0; n < 16; n++) begin
            issue(enc_r(CLASS_MOVE, SC_GPR2XCR, 4'(n), 4'd0, 5'd0, 3'd0) ^ 32'(n + 1),
                  rand_bits(32));
            issue(enc_r(3'(3 + n % 5), 3'd0, 4'(n), 4'd0, 5'd0, 3'd0), rand_bits(32));
            issue(enc_r(CLASS_PACKED_ARITH, 3'(5 + n % 3), 4'(n), 4'd1, 5'd2, 3'd0), '0);
            issue(enc_r(CLASS_BITWISE, 3'(2 + n % 6), 4'(n), 4'd1, 5'd2, 3'd0), '0);
            issue(enc_r(CLASS_MOVE, 3'(3 + n % 5), 4'(n), 4'd1, 5'd2, 3'd0), rand_bits(32));
            issue(enc_r(CLASS_PACKED_ARITH, 3'(n % 5), 4'(n), 4'd1, 5'd2, 3'(5 + n % 3)), '0);
            read_xcr(4'(n));                // Must still hold the old value
        end
        drain();

        for (int n = 0; n < 400; n++) begin
            issue(rand_insn(), rand_bits(32));
            if (rand_bits(3) == 32'd0) begin
                idle(1 + int'(rand_bits(2)));
            end
        end
        for (int i = 0; i < 16; i++) begin
            read_xcr(4'(i));
        end
        drain();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+verilog
+incdir+verification
verilog/cop_pkg.sv
verilog/cop_idecode.sv
verilog/cop_regfile.sv
verilog/cop_palu.sv
verilog/cop_top.sv
verification/tb_cop_top.sv

// ==== Makefile ====
# Verilator build and run for the coprocessor testbench

VERILATOR ?= verilator
TOP       ?= tb_cop_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
BIN       := $(OBJ_DIR)/V$(TOP)

SOURCES := $(wildcard verilog/*.sv verilog/*.svh verification/*.sv verification/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation is the test result
run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
